// File: Makefile
VERILATOR ?= verilator
TOP       ?= issue_core_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: build.f
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/dispatch_stage.sv
rtl/prf.sv
rtl/rs.sv
rtl/alu.sv
rtl/mul.sv
rtl/cdb_arbiter.sv
rtl/rob.sv
rtl/issue_core.sv
test/issue_core_tb.sv

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  issue,
    input  core_pkg::fu_packet_t  fu_packet,
    input  logic                  grant,   // cdb won this cycle
    output core_pkg::cdb_packet_t result,
    output logic                  stall
);

    logic [core_pkg::xlen-1:0] opa;
    logic [core_pkg::xlen-1:0] opb;
    logic [core_pkg::xlen-1:0] alu_value;

    assign opa   = fu_packet.opa_value;
    assign opb   = fu_packet.opb_value;
    assign stall = result.valid && !grant;  // held result blocks issue

    always_comb begin
        case (fu_packet.alu_func)
            isa_pkg::alu_add: alu_value = opa + opb;
            isa_pkg::alu_sub: alu_value = opa - opb;
            isa_pkg::alu_and: alu_value = opa & opb;
            isa_pkg::alu_or:  alu_value = opa | opb;
            isa_pkg::alu_xor: alu_value = opa ^ opb;
            isa_pkg::alu_sll: alu_value = opa << opb[4:0];
            isa_pkg::alu_srl: alu_value = opa >> opb[4:0];
            isa_pkg::alu_slt: alu_value = {{(core_pkg::xlen-1){1'b0}},
                                           $signed(opa) < $signed(opb)};
            default:          alu_value = '0;  // mul never routed here
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else if (issue) begin
            result.valid         <= 1'b1;
            result.dest_preg_idx <= fu_packet.dest_preg_idx;
            result.rob_idx       <= fu_packet.rob_idx;
            result.value         <= alu_value;
        end else if (grant) begin
            result.valid <= 1'b0;  // broadcast done
        end
    end

endmodule

// File: rtl/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter (
    input  core_pkg::cdb_packet_t alu_result,
    input  core_pkg::cdb_packet_t mul_result,
    output logic                  alu_grant,
    output core_pkg::cdb_packet_t cdb
);

    // mul pipeline has no stall, so it always wins
    assign alu_grant = alu_result.valid && !mul_result.valid;

    always_comb begin
        if (mul_result.valid)
            cdb = mul_result;
        else if (alu_grant)
            cdb = alu_result;
        else
            cdb = '0;  // idle bus
    end

endmodule

// File: rtl/core_pkg.sv
package core_pkg;

    //////////////////////////////
    // core sizes
    //////////////////////////////

    localparam int xlen        = 32;
    localparam int prf_size    = 64;  // preg 0 hardwired zero
    localparam int prf_len     = 6;
    localparam int rob_size    = 8;
    localparam int rob_len     = 3;
    localparam int rs_alu_size = 4;
    localparam int rs_mul_size = 2;

    //////////////////////////////
    // packets between blocks
    //////////////////////////////

    // renamed instruction from the front end
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        isa_pkg::inst_t        inst;
        isa_pkg::opa_select_t  opa_select;
        isa_pkg::opb_select_t  opb_select;
        isa_pkg::alu_func_t    alu_func;
        isa_pkg::fu_type_t     fu_type;
        logic [prf_len-1:0]    opa_preg_idx;
        logic [prf_len-1:0]    opb_preg_idx;
        logic [prf_len-1:0]    dest_preg_idx;
    } id_packet_t;

    typedef struct packed {
        logic                  valid;
        logic                  opa_ready;
        logic [xlen-1:0]       opa_value;
        logic                  opb_ready;
        logic [xlen-1:0]       opb_value;
        logic [prf_len-1:0]    opa_preg_idx;  // wake-up tag a
        logic [prf_len-1:0]    opb_preg_idx;  // wake-up tag b
        logic [prf_len-1:0]    dest_preg_idx;
        logic [rob_len-1:0]    rob_idx;
        isa_pkg::alu_func_t    alu_func;
    } rs_entry_t;

    typedef struct packed {
        logic [xlen-1:0]       opa_value;
        logic [xlen-1:0]       opb_value;
        isa_pkg::alu_func_t    alu_func;
        logic [prf_len-1:0]    dest_preg_idx;
        logic [rob_len-1:0]    rob_idx;
    } fu_packet_t;

    typedef struct packed {
        logic                  valid;
        logic [prf_len-1:0]    dest_preg_idx;
        logic [rob_len-1:0]    rob_idx;
        logic [xlen-1:0]       value;
    } cdb_packet_t;

    typedef struct packed {
        logic                  valid;
        logic [prf_len-1:0]    dest_preg_idx;
        logic [xlen-1:0]       value;
    } commit_packet_t;

endpackage

// File: rtl/dispatch_stage.sv
`timescale 1ns/1ps

module dispatch_stage (
    input  logic                         dispatch_enable,
    input  core_pkg::id_packet_t         id_packet,
    input  logic                         rob_full,
    input  logic                         rs_alu_full,
    input  logic                         rs_mul_full,
    input  logic [core_pkg::rob_len-1:0] rob_tail,
    input  logic                         opa_ready,  // from prf
    input  logic [core_pkg::xlen-1:0]    opa_value,
    input  logic                         opb_ready,
    input  logic [core_pkg::xlen-1:0]    opb_value,
    output logic                         dispatch_accept,
    output logic                         alu_dispatch,
    output logic                         mul_dispatch,
    output core_pkg::rs_entry_t          rs_entry
);

    logic is_mul;
    logic target_full;

    // steering and acceptance
    assign is_mul          = (id_packet.fu_type == isa_pkg::fu_mul);
    assign target_full     = is_mul ? rs_mul_full : rs_alu_full;
    assign dispatch_accept = dispatch_enable && id_packet.valid && !rob_full && !target_full;
    assign alu_dispatch    = dispatch_accept && !is_mul;
    assign mul_dispatch    = dispatch_accept && is_mul;

    always_comb begin
        rs_entry               = '0;
        rs_entry.valid         = id_packet.valid;
        rs_entry.opa_preg_idx  = id_packet.opa_preg_idx;
        rs_entry.opb_preg_idx  = id_packet.opb_preg_idx;
        rs_entry.dest_preg_idx = id_packet.dest_preg_idx;
        rs_entry.rob_idx       = rob_tail;  // slot allocated this cycle
        rs_entry.alu_func      = id_packet.alu_func;

        // opa mux, non register sources are ready at once
        rs_entry.opa_ready = 1'b1;
        case (id_packet.opa_select)
            isa_pkg::opa_is_rs1: begin
                rs_entry.opa_ready = opa_ready;
                rs_entry.opa_value = opa_value;
            end
            isa_pkg::opa_is_pc: rs_entry.opa_value = id_packet.pc;
            default:            rs_entry.opa_value = '0;
        endcase

        // opb mux
        rs_entry.opb_ready = 1'b1;
        case (id_packet.opb_select)
            isa_pkg::opb_is_rs2: begin
                rs_entry.opb_ready = opb_ready;
                rs_entry.opb_value = opb_value;
            end
            isa_pkg::opb_is_i_imm: rs_entry.opb_value =
                {{(core_pkg::xlen-12){id_packet.inst.i.imm[11]}}, id_packet.inst.i.imm};
            isa_pkg::opb_is_u_imm: rs_entry.opb_value = {id_packet.inst.u.imm, 12'h000};
            default:               rs_entry.opb_value = '0;
        endcase
    end

endmodule

// File: rtl/isa_pkg.sv
package isa_pkg;

    //////////////////////////////
    // operand selects
    //////////////////////////////

    typedef enum logic [1:0] {
        opa_is_rs1  = 2'h0,  // physical source a
        opa_is_pc   = 2'h1,
        opa_is_zero = 2'h2
    } opa_select_t;

    typedef enum logic [1:0] {
        opb_is_rs2   = 2'h0,  // physical source b
        opb_is_i_imm = 2'h1,  // sign extended 12 bit
        opb_is_u_imm = 2'h2   // upper 20 bits
    } opb_select_t;

    // functions seen by both units
    typedef enum logic [3:0] {
        alu_add = 4'h0,
        alu_sub = 4'h1,
        alu_and = 4'h2,
        alu_or  = 4'h3,
        alu_xor = 4'h4,
        alu_sll = 4'h5,
        alu_srl = 4'h6,
        alu_slt = 4'h7,  // signed compare
        alu_mul = 4'h8   // low word only
    } alu_func_t;

    typedef enum logic {
        fu_alu = 1'b0,
        fu_mul = 1'b1
    } fu_type_t;

    //////////////////////////////
    // instruction word views
    //////////////////////////////

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_format_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_format_t;

    // same 32 bits, read per immediate kind
    typedef union packed {
        i_format_t i;
        u_format_t u;
    } inst_t;

endpackage

// File: rtl/issue_core.sv
`timescale 1ns/1ps

module issue_core (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     dispatch_enable,
    input  core_pkg::id_packet_t     id_packet,
    output logic                     rob_full,
    output logic                     rs_alu_full,
    output logic                     rs_mul_full,
    output core_pkg::commit_packet_t commit
);

    logic                         dispatch_accept;
    logic                         alu_dispatch;   // dispatch -> rs_alu
    logic                         mul_dispatch;   // dispatch -> rs_mul
    core_pkg::rs_entry_t          rs_entry;
    logic                         opa_ready;      // prf -> dispatch
    logic [core_pkg::xlen-1:0]    opa_value;
    logic                         opb_ready;
    logic [core_pkg::xlen-1:0]    opb_value;
    logic [core_pkg::rob_len-1:0] rob_tail;       // rob -> dispatch
    logic                         alu_issue;
    logic                         mul_issue;
    core_pkg::fu_packet_t         alu_fu_packet;
    core_pkg::fu_packet_t         mul_fu_packet;
    core_pkg::cdb_packet_t        alu_result;     // held until granted
    core_pkg::cdb_packet_t        mul_result;
    core_pkg::cdb_packet_t        cdb;            // to prf, rs, rob
    logic                         alu_grant;
    logic                         alu_stall;

    //////////////////////////////
    // front: dispatch and operands
    //////////////////////////////

    dispatch_stage dispatch_stage0 (
        .dispatch_enable, .id_packet, .rob_full, .rs_alu_full, .rs_mul_full,
        .rob_tail, .opa_ready, .opa_value, .opb_ready, .opb_value,
        .dispatch_accept, .alu_dispatch, .mul_dispatch, .rs_entry
    );

    prf prf0 (
        .clock, .reset,
        .opa_preg_idx(id_packet.opa_preg_idx),
        .opb_preg_idx(id_packet.opb_preg_idx),
        .dispatch_accept,
        .dest_preg_idx(id_packet.dest_preg_idx),
        .cdb, .opa_ready, .opa_value, .opb_ready, .opb_value
    );

    //////////////////////////////
    // stations and units
    //////////////////////////////

    rs #(.rs_size(core_pkg::rs_alu_size)) rs_alu0 (
        .clock, .reset, .dispatch(alu_dispatch), .rs_entry_in(rs_entry), .cdb,
        .stall(alu_stall), .full(rs_alu_full), .issue(alu_issue), .fu_packet(alu_fu_packet)
    );

    rs #(.rs_size(core_pkg::rs_mul_size)) rs_mul0 (
        .clock, .reset, .dispatch(mul_dispatch), .rs_entry_in(rs_entry), .cdb,
        .stall(1'b0), .full(rs_mul_full), .issue(mul_issue), .fu_packet(mul_fu_packet)
    );

    alu alu0 (
        .clock, .reset, .issue(alu_issue), .fu_packet(alu_fu_packet),
        .grant(alu_grant), .result(alu_result), .stall(alu_stall)
    );

    mul mul0 (
        .clock, .reset, .issue(mul_issue), .fu_packet(mul_fu_packet), .result(mul_result)
    );

    //////////////////////////////
    // broadcast and retire
    //////////////////////////////

    cdb_arbiter cdb_arbiter0 (.alu_result, .mul_result, .alu_grant, .cdb);

    rob rob0 (
        .clock, .reset, .dispatch_accept,
        .dest_preg_idx(id_packet.dest_preg_idx),
        .cdb, .rob_tail, .rob_full, .commit
    );

endmodule

// File: rtl/mul.sv
`timescale 1ns/1ps

module mul (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  issue,
    input  core_pkg::fu_packet_t  fu_packet,
    output core_pkg::cdb_packet_t result
);

    logic [2:0]                   stage_valid;
    logic [core_pkg::prf_len-1:0] stage_dest [3];
    logic [core_pkg::rob_len-1:0] stage_rob  [3];
    logic [core_pkg::xlen-1:0]    stage_sum  [3];  // running low word
    logic [core_pkg::xlen-1:0]    opa_q      [2];
    logic [core_pkg::xlen-1:0]    opb_q      [2];
    logic [core_pkg::xlen-1:0]    cross_hl;
    logic [core_pkg::xlen-1:0]    cross_lh;

    // cross terms only count in the upper half of the low word
    assign cross_hl = opa_q[0][31:16] * opb_q[0][15:0];
    assign cross_lh = opa_q[1][15:0] * opb_q[1][31:16];

    always_ff @(posedge clock) begin
        if (reset)
            stage_valid <= '0;
        else
            stage_valid <= {stage_valid[1:0], issue};  // never stops
    end

    always_ff @(posedge clock) begin
        // stage 0, low halves
        stage_sum[0]  <= fu_packet.opa_value[15:0] * fu_packet.opb_value[15:0];
        opa_q[0]      <= fu_packet.opa_value;
        opb_q[0]      <= fu_packet.opb_value;
        stage_dest[0] <= fu_packet.dest_preg_idx;
        stage_rob[0]  <= fu_packet.rob_idx;
        // stage 1, a high times b low
        stage_sum[1]  <= stage_sum[0] + {cross_hl[15:0], 16'h0000};
        opa_q[1]      <= opa_q[0];
        opb_q[1]      <= opb_q[0];
        stage_dest[1] <= stage_dest[0];
        stage_rob[1]  <= stage_rob[0];
        // stage 2, a low times b high
        stage_sum[2]  <= stage_sum[1] + {cross_lh[15:0], 16'h0000};
        stage_dest[2] <= stage_dest[1];
        stage_rob[2]  <= stage_rob[1];
    end

    assign result.valid         = stage_valid[2];
    assign result.dest_preg_idx = stage_dest[2];
    assign result.rob_idx       = stage_rob[2];
    assign result.value         = stage_sum[2];

endmodule

// File: rtl/prf.sv
`timescale 1ns/1ps

module prf (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [core_pkg::prf_len-1:0] opa_preg_idx,
    input  logic [core_pkg::prf_len-1:0] opb_preg_idx,
    input  logic                         dispatch_accept,
    input  logic [core_pkg::prf_len-1:0] dest_preg_idx,  // new writer
    input  core_pkg::cdb_packet_t        cdb,
    output logic                         opa_ready,
    output logic [core_pkg::xlen-1:0]    opa_value,
    output logic                         opb_ready,
    output logic [core_pkg::xlen-1:0]    opb_value
);

    logic [core_pkg::xlen-1:0]     values [core_pkg::prf_size];
    logic [core_pkg::prf_size-1:0] ready;

    // one read port, preg 0 first, then cdb bypass, then storage
    function automatic logic [core_pkg::xlen:0] read_port(
        input logic [core_pkg::prf_len-1:0] idx
    );
        if (idx == '0)
            return {1'b1, {core_pkg::xlen{1'b0}}};
        else if (cdb.valid && cdb.dest_preg_idx == idx)
            return {1'b1, cdb.value};  // broadcast this cycle
        else
            return {ready[idx], values[idx]};
    endfunction

    always_comb begin
        {opa_ready, opa_value} = read_port(opa_preg_idx);
        {opb_ready, opb_value} = read_port(opb_preg_idx);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ready <= '1;  // every preg holds a committed value
        end else begin
            if (cdb.valid)
                ready[cdb.dest_preg_idx] <= 1'b1;
            if (dispatch_accept && dest_preg_idx != '0)
                ready[dest_preg_idx] <= 1'b0;  // pending writer
        end
    end

    always_ff @(posedge clock) begin
        if (cdb.valid)
            values[cdb.dest_preg_idx] <= cdb.value;
    end

endmodule

// File: rtl/rob.sv
`timescale 1ns/1ps

module rob (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          dispatch_accept,
    input  logic [core_pkg::prf_len-1:0]  dest_preg_idx,
    input  core_pkg::cdb_packet_t         cdb,
    output logic [core_pkg::rob_len-1:0]  rob_tail,
    output logic                          rob_full,
    output core_pkg::commit_packet_t      commit
);

    logic [core_pkg::rob_size-1:0] done;
    logic [core_pkg::prf_len-1:0]  dest  [core_pkg::rob_size];
    logic [core_pkg::xlen-1:0]     value [core_pkg::rob_size];
    logic [core_pkg::rob_len-1:0]  head;
    logic [core_pkg::rob_len:0]    count;  // one extra bit for full
    logic                          retire;

    assign retire   = (count != '0) && done[head];
    assign rob_full = (count == (core_pkg::rob_len+1)'(core_pkg::rob_size));

    //////////////////////////////
    // pointers and done bits
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head         <= '0;
            rob_tail     <= '0;
            count        <= '0;
            done         <= '0;
            commit.valid <= 1'b0;
        end else begin
            if (cdb.valid)
                done[cdb.rob_idx] <= 1'b1;
            if (dispatch_accept) begin
                done[rob_tail] <= 1'b0;
                rob_tail       <= rob_tail + 1'b1;  // wraps at 8
            end
            if (retire)
                head <= head + 1'b1;
            case ({dispatch_accept, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none or both
            endcase
            commit.valid <= retire;
        end
    end

    // entry payload and commit report
    always_ff @(posedge clock) begin
        if (dispatch_accept)
            dest[rob_tail] <= dest_preg_idx;
        if (cdb.valid)
            value[cdb.rob_idx] <= cdb.value;
        commit.dest_preg_idx <= dest[head];
        commit.value         <= value[head];
    end

endmodule

// File: rtl/rs.sv
`timescale 1ns/1ps

module rs #(
    parameter int rs_size = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch,
    input  core_pkg::rs_entry_t   rs_entry_in,
    input  core_pkg::cdb_packet_t cdb,
    input  logic                  stall,  // unit cannot take work
    output logic                  full,
    output logic                  issue,
    output core_pkg::fu_packet_t  fu_packet
);

    core_pkg::rs_entry_t           entries [rs_size];
    logic [rs_size-1:0]            occupied;
    logic [$clog2(rs_size)-1:0]    alloc_idx;
    logic [$clog2(rs_size)-1:0]    issue_idx;
    logic                          issue_found;

    // priority scan, walking down so the lowest index wins
    always_comb begin
        issue_found = 1'b0;
        issue_idx   = '0;
        alloc_idx   = '0;
        for (int i = rs_size - 1; i >= 0; i--) begin
            occupied[i] = entries[i].valid;
            if (entries[i].valid && entries[i].opa_ready && entries[i].opb_ready) begin
                issue_found = 1'b1;
                issue_idx   = ($clog2(rs_size))'(i);
            end
            if (!entries[i].valid)
                alloc_idx = ($clog2(rs_size))'(i);  // lowest free
        end
    end

    assign full  = &occupied;
    assign issue = issue_found && !stall;

    assign fu_packet.opa_value     = entries[issue_idx].opa_value;
    assign fu_packet.opb_value     = entries[issue_idx].opb_value;
    assign fu_packet.alu_func      = entries[issue_idx].alu_func;
    assign fu_packet.dest_preg_idx = entries[issue_idx].dest_preg_idx;
    assign fu_packet.rob_idx       = entries[issue_idx].rob_idx;

    //////////////////////////////
    // wake-up, issue, allocate
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rs_size; i++)
                entries[i].valid <= 1'b0;
        end else begin
            for (int i = 0; i < rs_size; i++) begin
                // ready operands keep their value, tag may be stale
                if (cdb.valid && !entries[i].opa_ready &&
                    entries[i].opa_preg_idx == cdb.dest_preg_idx) begin
                    entries[i].opa_ready <= 1'b1;
                    entries[i].opa_value <= cdb.value;
                end
                if (cdb.valid && !entries[i].opb_ready &&
                    entries[i].opb_preg_idx == cdb.dest_preg_idx) begin
                    entries[i].opb_ready <= 1'b1;
                    entries[i].opb_value <= cdb.value;
                end
            end
            if (issue)
                entries[issue_idx].valid <= 1'b0;  // slot freed
            if (dispatch)
                entries[alloc_idx] <= rs_entry_in;  // never full here
        end
    end

endmodule

// File: test/issue_core_tb.sv
`timescale 1ns/1ps

module issue_core_tb;

    localparam int num_directed = 46;
    localparam int num_random   = 200;
    localparam int cycle_limit  = 20 * (num_directed + num_random) + 200;

    logic                     clock;
    logic                     reset;
    logic                     dispatch_enable;
    core_pkg::id_packet_t     id_packet;
    logic                     rob_full;
    logic                     rs_alu_full;
    logic                     rs_mul_full;
    core_pkg::commit_packet_t commit;

    core_pkg::commit_packet_t expected [$];  // program order results
    logic [31:0]              model_regs [64];
    logic [5:0]               history [$];   // last 16 destinations
    logic [5:0]               next_dest;
    logic [5:0]               last_dest;
    logic [5:0]               a_dest;
    logic [5:0]               b_dest;
    int                       seed;
    int                       cycles;
    int                       accepted_count;
    int                       commit_count;
    int                       r;
    logic                     saw_rob_full;
    string                    test_name;

    issue_core DUT (
        .clock, .reset, .dispatch_enable, .id_packet,
        .rob_full, .rs_alu_full, .rs_mul_full, .commit
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("ERROR %s %s: expected %h actual %h", test_name, what, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // reference results straight from the isa rules
    function automatic logic [31:0] golden(input isa_pkg::alu_func_t func,
                                           input logic [31:0] a, input logic [31:0] b);
        case (func)
            isa_pkg::alu_add: return a + b;
            isa_pkg::alu_sub: return a - b;
            isa_pkg::alu_and: return a & b;
            isa_pkg::alu_or:  return a | b;
            isa_pkg::alu_xor: return a ^ b;
            isa_pkg::alu_sll: return a << b[4:0];
            isa_pkg::alu_srl: return a >> b[4:0];
            isa_pkg::alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:          return a * b;  // low word of product
        endcase
    endfunction

    function automatic logic [5:0] pick_source();
        int pick;
        pick = $unsigned($random(seed)) % 20;
        if (history.size() == 0 || pick >= 16)
            return 6'd0;  // zero register now and then
        return history[pick % history.size()];
    endfunction

    //////////////////////////////
    // one cycle of monitoring
    //////////////////////////////

    task automatic step();
        core_pkg::commit_packet_t exp_c;
        @(negedge clock);
        cycles++;
        if (cycles > cycle_limit)
            fail_with("run exceeded its cycle limit, results stopped arriving");
        if (commit.valid) begin
            if (expected.size() == 0)
                fail_with("commit seen with no instruction outstanding");
            exp_c = expected.pop_front();
            check_value("commit dest", 32'(exp_c.dest_preg_idx), 32'(commit.dest_preg_idx));
            check_value("commit value", exp_c.value, commit.value);
            commit_count++;
        end
        // rob occupancy is accepted minus committed
        check_value("rob_full", 32'(accepted_count - commit_count == 8), 32'(rob_full));
        if (rob_full)
            saw_rob_full = 1'b1;
    endtask

    task automatic set_idle();
        dispatch_enable = 1'b0;
        id_packet       = '0;
    endtask

    // acts as renamer, offers until accepted
    task automatic dispatch_inst(input isa_pkg::alu_func_t func, input isa_pkg::opa_select_t asel,
                                 input isa_pkg::opb_select_t bsel,
                                 input logic [5:0] src_a, input logic [5:0] src_b);
        core_pkg::id_packet_t p;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [31:0]          word;
        logic [31:0]          pc;
        logic                 target_full;
        logic                 accepted;
        word = $random(seed);
        pc   = $random(seed) & 32'hffff_fffc;
        p               = '0;
        p.valid         = 1'b1;
        p.pc            = pc;
        p.inst          = word;
        p.opa_select    = asel;
        p.opb_select    = bsel;
        p.alu_func      = func;
        p.fu_type       = (func == isa_pkg::alu_mul) ? isa_pkg::fu_mul : isa_pkg::fu_alu;
        p.opa_preg_idx  = src_a;
        p.opb_preg_idx  = src_b;
        p.dest_preg_idx = next_dest;
        case (asel)
            isa_pkg::opa_is_rs1: a = model_regs[src_a];
            isa_pkg::opa_is_pc:  a = pc;
            default:             a = 32'h0;
        endcase
        case (bsel)
            isa_pkg::opb_is_rs2:   b = model_regs[src_b];
            isa_pkg::opb_is_i_imm: b = {{20{word[31]}}, word[31:20]};
            default:               b = {word[31:12], 12'h000};
        endcase
        accepted = 1'b0;
        while (!accepted) begin
            step();
            id_packet       = p;
            dispatch_enable = 1'b1;
            target_full     = (p.fu_type == isa_pkg::fu_mul) ? rs_mul_full : rs_alu_full;
            accepted        = !rob_full && !target_full;  // flags hold until the edge
        end
        model_regs[next_dest] = golden(func, a, b);
        expected.push_back({1'b1, next_dest, model_regs[next_dest]});
        history.push_back(next_dest);
        if (history.size() > 16)
            void'(history.pop_front());
        last_dest = next_dest;
        accepted_count++;
        next_dest = (next_dest == 6'd63) ? 6'd1 : next_dest + 6'd1;
    endtask

    task automatic drain();
        step();
        set_idle();
        while (expected.size() != 0)
            step();
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        seed           = 13401;
        cycles         = 0;
        accepted_count = 0;
        commit_count   = 0;
        next_dest      = 6'd1;
        last_dest      = 6'd0;
        saw_rob_full   = 1'b0;
        reset          = 1'b1;
        set_idle();
        for (int i = 0; i < 64; i++)
            model_regs[i] = 32'h0;

        test_name = "reset";
        repeat (4) begin
            @(negedge clock);
            check_value("commit.valid", 32'h0, 32'(commit.valid));
            check_value("rob_full", 32'h0, 32'(rob_full));
            check_value("rs_alu_full", 32'h0, 32'(rs_alu_full));
            check_value("rs_mul_full", 32'h0, 32'(rs_mul_full));
        end
        reset = 1'b0;
        step();
        check_value("rs_alu_full", 32'h0, 32'(rs_alu_full));
        check_value("rs_mul_full", 32'h0, 32'(rs_mul_full));

        // every function against every operand select
        test_name = "select_ops";
        for (int i = 0; i < 27; i++)
            dispatch_inst(isa_pkg::alu_func_t'(i % 9), isa_pkg::opa_select_t'(i % 3),
                          isa_pkg::opb_select_t'((i / 3) % 3), pick_source(), pick_source());
        drain();

        test_name = "mul_station_full";
        dispatch_inst(isa_pkg::alu_mul, isa_pkg::opa_is_pc, isa_pkg::opb_is_i_imm, 0, 0);
        a_dest = last_dest;
        dispatch_inst(isa_pkg::alu_mul, isa_pkg::opa_is_rs1, isa_pkg::opb_is_i_imm, a_dest, 0);
        dispatch_inst(isa_pkg::alu_mul, isa_pkg::opa_is_rs1, isa_pkg::opb_is_rs2, a_dest, a_dest);
        step();
        set_idle();
        check_value("rs_mul_full", 32'h1, 32'(rs_mul_full));
        drain();

        // four adds park behind one multiply
        test_name = "alu_station_full";
        dispatch_inst(isa_pkg::alu_mul, isa_pkg::opa_is_pc, isa_pkg::opb_is_i_imm, 0, 0);
        a_dest = last_dest;
        repeat (4)
            dispatch_inst(isa_pkg::alu_add, isa_pkg::opa_is_rs1, isa_pkg::opb_is_i_imm, a_dest, 0);
        step();
        set_idle();
        check_value("rs_alu_full", 32'h1, 32'(rs_alu_full));
        drain();

        test_name    = "rob_full";
        saw_rob_full = 1'b0;
        dispatch_inst(isa_pkg::alu_mul, isa_pkg::opa_is_pc, isa_pkg::opb_is_i_imm, 0, 0);
        a_dest = last_dest;
        dispatch_inst(isa_pkg::alu_mul, isa_pkg::opa_is_rs1, isa_pkg::opb_is_rs2, a_dest, a_dest);
        b_dest = last_dest;
        dispatch_inst(isa_pkg::alu_mul, isa_pkg::opa_is_rs1, isa_pkg::opb_is_rs2, b_dest, a_dest);
        repeat (8)
            dispatch_inst(isa_pkg::alu_or, isa_pkg::opa_is_zero, isa_pkg::opb_is_i_imm, 0, 0);
        drain();
        check_value("rob_full seen", 32'h1, 32'(saw_rob_full));

        // mixed traffic with cdb conflicts and bubbles
        test_name = "random_mix";
        for (int i = 0; i < num_random; i++) begin
            r = $unsigned($random(seed));
            if (r % 6 == 0) begin
                step();
                set_idle();
            end
            dispatch_inst((r % 4 == 1) ? isa_pkg::alu_mul : isa_pkg::alu_func_t'((r >> 3) % 8),
                          isa_pkg::opa_select_t'((r >> 6) % 3),
                          isa_pkg::opb_select_t'((r >> 9) % 3),
                          pick_source(), pick_source());
        end
        drain();

        // late or duplicated commits show up here
        test_name = "final_count";
        repeat (4)
            step();
        $display("Test passed");
        $finish;
    end

endmodule
